// ==== hw/axi_pkg.sv ====
package axi_pkg;

  // id field carried on ar and r
  localparam int AXI_ID_W = 4;

  // address and data bus widths of the master port
  localparam int AXI_ADDR_W = 32;
  localparam int AXI_DATA_W = 32;

  // one strobe bit per data byte
  localparam int AXI_STRB_W = 4;

  // read ids, one per core port
  // returned data is steered back by these values
  localparam logic [AXI_ID_W-1:0] AXI_ID_FETCH = AXI_ID_W'(0);
  localparam logic [AXI_ID_W-1:0] AXI_ID_DATA  = AXI_ID_W'(1);

endpackage

// ==== hw/mem_port_pkg.sv ====
package mem_port_pkg;

  // core side request widths
  localparam int ADDR_W = 32;
  localparam int DATA_W = 32;
  localparam int STRB_W = 4;

  // data port operation
  typedef enum logic {
    MEM_LOAD  = 1'b0,
    MEM_STORE = 1'b1
  } mem_op_e;

  // single outstanding read
  typedef enum logic [1:0] {
    RD_IDLE = 2'd0,
    RD_ADDR = 2'd1,
    RD_DATA = 2'd2
  } rd_state_e;

  // store drain, one entry at a time
  typedef enum logic [1:0] {
    WB_IDLE = 2'd0,
    WB_SEND = 2'd1,
    WB_RESP = 2'd2
  } wb_state_e;

  localparam int WBUF_DEPTH = 4;
  localparam int WBUF_PTR_W = 2;

  localparam int PERF_CNT_W = 32;

endpackage

// ==== hw/mem_req_arbiter.sv ====
`timescale 1ns/1ps

module mem_req_arbiter (
  input  logic                         aclk,
  input  logic                         i_reset,
  // fetch port
  input  logic                         i_if_valid,
  input  logic [mem_port_pkg::ADDR_W-1:0] i_if_addr,
  input  logic                         i_if_uncached,
  output logic                         o_if_ready,
  // data port
  input  logic                         i_d_valid,
  input  mem_port_pkg::mem_op_e        i_d_op,
  input  logic [mem_port_pkg::ADDR_W-1:0] i_d_addr,
  input  logic                         i_d_uncached,
  input  logic [mem_port_pkg::STRB_W-1:0] i_d_wstrb,
  input  logic [mem_port_pkg::DATA_W-1:0] i_d_wdata,
  output logic                         o_d_ready,
  // read engine
  input  logic                         i_rd_ready,
  output logic                         o_rd_valid,
  output logic [mem_port_pkg::ADDR_W-1:0] o_rd_addr,
  output logic [axi_pkg::AXI_ID_W-1:0] o_rd_id,
  // write buffer
  input  logic                         i_wb_push_ready,
  input  logic                         i_wb_empty,
  output logic                         o_wb_push_valid,
  output logic [mem_port_pkg::ADDR_W-1:0] o_wb_addr,
  output logic [mem_port_pkg::STRB_W-1:0] o_wb_strb,
  output logic [mem_port_pkg::DATA_W-1:0] o_wb_data,
  output logic                         o_uncached_stall
);
  import mem_port_pkg::*;
  import axi_pkg::*;

  logic if_blocked;
  logic d_blocked;
  logic d_is_store;
  logic d_res_ready;
  logic if_elig;
  logic d_elig;
  logic grant_if;
  logic grant_d;
  logic last_was_d;

  // uncached traffic must not pass buffered stores
  assign if_blocked = i_if_uncached && !i_wb_empty;
  assign d_blocked  = i_d_uncached && !i_wb_empty;

  assign d_is_store  = (i_d_op == MEM_STORE);
  assign d_res_ready = d_is_store ? i_wb_push_ready : i_rd_ready;

  assign if_elig = i_if_valid && !if_blocked && i_rd_ready;
  assign d_elig  = i_d_valid && !d_blocked && d_res_ready;

  // round robin, data wins first after reset
  assign grant_d  = d_elig && (!if_elig || !last_was_d);
  assign grant_if = if_elig && !grant_d;

  always_ff @(posedge aclk) begin
    if (i_reset) begin
      last_was_d <= 1'b0;
    end else if (grant_d) begin
      last_was_d <= 1'b1;
    end else if (grant_if) begin
      last_was_d <= 1'b0;
    end
  end

  assign o_if_ready = grant_if;
  assign o_d_ready  = grant_d;

  assign o_rd_valid = grant_if || (grant_d && !d_is_store);
  assign o_rd_addr  = grant_d ? i_d_addr : i_if_addr;
  assign o_rd_id    = grant_d ? AXI_ID_DATA : AXI_ID_FETCH;

  assign o_wb_push_valid = grant_d && d_is_store;
  assign o_wb_addr       = i_d_addr;
  assign o_wb_strb       = i_d_wstrb;
  assign o_wb_data       = i_d_wdata;

  // held back by the uncached rule alone
  assign o_uncached_stall = (i_if_valid && if_blocked && i_rd_ready) ||
                            (i_d_valid && d_blocked && d_res_ready);

endmodule

// ==== hw/axi_read_engine.sv ====
`timescale 1ns/1ps

module axi_read_engine (
  input  logic                           aclk,
  input  logic                           i_reset,
  // request from the arbiter
  input  logic                           i_req_valid,
  input  logic [mem_port_pkg::ADDR_W-1:0] i_req_addr,
  input  logic [axi_pkg::AXI_ID_W-1:0]   i_req_id,
  output logic                           o_req_ready,
  // ar channel
  output logic [axi_pkg::AXI_ID_W-1:0]   o_arid,
  output logic [axi_pkg::AXI_ADDR_W-1:0] o_araddr,
  output logic                           o_arvalid,
  input  logic                           i_arready,
  // r channel
  input  logic [axi_pkg::AXI_ID_W-1:0]   i_rid,
  input  logic [axi_pkg::AXI_DATA_W-1:0] i_rdata,
  input  logic                           i_rvalid,
  output logic                           o_rready,
  // returns to the core ports
  output logic                           o_if_rvalid,
  output logic [mem_port_pkg::DATA_W-1:0] o_if_rdata,
  output logic                           o_d_rvalid,
  output logic [mem_port_pkg::DATA_W-1:0] o_d_rdata
);
  import mem_port_pkg::*;
  import axi_pkg::*;

  rd_state_e                 state;
  logic [ADDR_W-1:0]         req_addr;
  logic [AXI_ID_W-1:0]       req_id;
  logic [DATA_W-1:0]         ret_data;

  always_ff @(posedge aclk) begin
    if (i_reset) begin
      state       <= RD_IDLE;
      o_if_rvalid <= 1'b0;
      o_d_rvalid  <= 1'b0;
    end else begin
      o_if_rvalid <= 1'b0;
      o_d_rvalid  <= 1'b0;
      case (state)
        RD_IDLE: begin
          if (i_req_valid) begin
            state <= RD_ADDR;
          end
        end
        RD_ADDR: begin
          if (i_arready) begin
            state <= RD_DATA;
          end
        end
        RD_DATA: begin
          if (i_rvalid) begin
            state       <= RD_IDLE;
            o_if_rvalid <= (i_rid == AXI_ID_FETCH);
            o_d_rvalid  <= (i_rid == AXI_ID_DATA);
          end
        end
        default: state <= RD_IDLE;
      endcase
    end
  end

  // request and return payload
  always_ff @(posedge aclk) begin
    if (state == RD_IDLE && i_req_valid) begin
      req_addr <= i_req_addr;
      req_id   <= i_req_id;
    end
    if (state == RD_DATA && i_rvalid) begin
      ret_data <= i_rdata;
    end
  end

  assign o_req_ready = (state == RD_IDLE);
  assign o_arvalid   = (state == RD_ADDR);
  assign o_arid      = req_id;
  assign o_araddr    = req_addr;
  assign o_rready    = (state == RD_DATA);

  assign o_if_rdata = ret_data;
  assign o_d_rdata  = ret_data;

endmodule

// ==== hw/store_write_buffer.sv ====
`timescale 1ns/1ps

module store_write_buffer (
  input  logic                           aclk,
  input  logic                           i_reset,
  // push side
  input  logic                           i_push_valid,
  input  logic [mem_port_pkg::ADDR_W-1:0] i_push_addr,
  input  logic [mem_port_pkg::STRB_W-1:0] i_push_strb,
  input  logic [mem_port_pkg::DATA_W-1:0] i_push_data,
  output logic                           o_push_ready,
  output logic                           o_empty,
  // aw channel
  output logic [axi_pkg::AXI_ADDR_W-1:0] o_awaddr,
  output logic                           o_awvalid,
  input  logic                           i_awready,
  // w channel
  output logic [axi_pkg::AXI_DATA_W-1:0] o_wdata,
  output logic [axi_pkg::AXI_STRB_W-1:0] o_wstrb,
  output logic                           o_wvalid,
  input  logic                           i_wready,
  // b channel
  input  logic                           i_bvalid,
  output logic                           o_bready
);
  import mem_port_pkg::*;

  logic [ADDR_W-1:0]     buf_addr [WBUF_DEPTH];
  logic [STRB_W-1:0]     buf_strb [WBUF_DEPTH];
  logic [DATA_W-1:0]     buf_data [WBUF_DEPTH];
  logic [WBUF_PTR_W-1:0] wr_ptr;
  logic [WBUF_PTR_W-1:0] rd_ptr;
  logic [WBUF_PTR_W:0]   count;
  wb_state_e             state;
  logic                  aw_pend;
  logic                  w_pend;
  logic                  push;
  logic                  pop;

  assign o_push_ready = (count != (WBUF_PTR_W+1)'(WBUF_DEPTH));
  assign push         = i_push_valid && o_push_ready;
  // head entry leaves only once its write response is back
  assign pop          = (state == WB_RESP) && i_bvalid;

  always_ff @(posedge aclk) begin
    if (push) begin
      buf_addr[wr_ptr] <= i_push_addr;
      buf_strb[wr_ptr] <= i_push_strb;
      buf_data[wr_ptr] <= i_push_data;
    end
  end

  always_ff @(posedge aclk) begin
    if (i_reset) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) begin
        wr_ptr <= wr_ptr + WBUF_PTR_W'(1);
      end
      if (pop) begin
        rd_ptr <= rd_ptr + WBUF_PTR_W'(1);
      end
      if (push && !pop) begin
        count <= count + (WBUF_PTR_W+1)'(1);
      end else if (pop && !push) begin
        count <= count - (WBUF_PTR_W+1)'(1);
      end
    end
  end

  // aw and w are accepted independently
  always_ff @(posedge aclk) begin
    if (i_reset) begin
      state   <= WB_IDLE;
      aw_pend <= 1'b0;
      w_pend  <= 1'b0;
    end else begin
      case (state)
        WB_IDLE: begin
          if (count != '0) begin
            state   <= WB_SEND;
            aw_pend <= 1'b1;
            w_pend  <= 1'b1;
          end
        end
        WB_SEND: begin
          if (i_awready) begin
            aw_pend <= 1'b0;
          end
          if (i_wready) begin
            w_pend <= 1'b0;
          end
          if ((!aw_pend || i_awready) && (!w_pend || i_wready)) begin
            state <= WB_RESP;
          end
        end
        WB_RESP: begin
          if (i_bvalid) begin
            state <= WB_IDLE;
          end
        end
        default: state <= WB_IDLE;
      endcase
    end
  end

  assign o_awaddr  = buf_addr[rd_ptr];
  assign o_awvalid = aw_pend;
  assign o_wdata   = buf_data[rd_ptr];
  assign o_wstrb   = buf_strb[rd_ptr];
  assign o_wvalid  = w_pend;
  assign o_bready  = (state == WB_RESP);

  assign o_empty = (count == '0) && (state == WB_IDLE);

endmodule

// ==== hw/mem_perf_counter.sv ====
`timescale 1ns/1ps

module mem_perf_counter (
  input  logic                                aclk,
  input  logic                                i_reset,
  input  logic                                i_if_valid,
  input  logic                                i_if_ready,
  input  logic                                i_d_valid,
  input  logic                                i_d_ready,
  input  mem_port_pkg::mem_op_e               i_d_op,
  input  logic                                i_uncached_stall,
  output logic [mem_port_pkg::PERF_CNT_W-1:0] o_fetch_count,
  output logic [mem_port_pkg::PERF_CNT_W-1:0] o_load_count,
  output logic [mem_port_pkg::PERF_CNT_W-1:0] o_store_count,
  output logic [mem_port_pkg::PERF_CNT_W-1:0] o_stall_count
);
  import mem_port_pkg::*;

  logic [3:0]            inc;
  logic [PERF_CNT_W-1:0] cnt [4];
  logic                  d_fire;

  assign d_fire = i_d_valid && i_d_ready;

  // fetch, load, store, stall
  assign inc[0] = i_if_valid && i_if_ready;
  assign inc[1] = d_fire && (i_d_op == MEM_LOAD);
  assign inc[2] = d_fire && (i_d_op == MEM_STORE);
  assign inc[3] = i_uncached_stall;

  always_ff @(posedge aclk) begin
    for (int i = 0; i < 4; i++) begin
      if (i_reset) begin
        cnt[i] <= '0;
      end else if (inc[i]) begin
        cnt[i] <= cnt[i] + PERF_CNT_W'(1);
      end
    end
  end

  assign o_fetch_count = cnt[0];
  assign o_load_count  = cnt[1];
  assign o_store_count = cnt[2];
  assign o_stall_count = cnt[3];

endmodule

// ==== hw/mem_port_top.sv ====
`timescale 1ns/1ps

module mem_port_top (
  input  logic                                aclk,
  input  logic                                i_reset,
  // fetch port
  input  logic                                i_if_valid,
  input  logic [mem_port_pkg::ADDR_W-1:0]     i_if_addr,
  input  logic                                i_if_uncached,
  output logic                                o_if_ready,
  output logic                                o_if_rvalid,
  output logic [mem_port_pkg::DATA_W-1:0]     o_if_rdata,
  // data port
  input  logic                                i_d_valid,
  input  mem_port_pkg::mem_op_e               i_d_op,
  input  logic [mem_port_pkg::ADDR_W-1:0]     i_d_addr,
  input  logic                                i_d_uncached,
  input  logic [mem_port_pkg::STRB_W-1:0]     i_d_wstrb,
  input  logic [mem_port_pkg::DATA_W-1:0]     i_d_wdata,
  output logic                                o_d_ready,
  output logic                                o_d_rvalid,
  output logic [mem_port_pkg::DATA_W-1:0]     o_d_rdata,
  // counters
  output logic [mem_port_pkg::PERF_CNT_W-1:0] o_fetch_count,
  output logic [mem_port_pkg::PERF_CNT_W-1:0] o_load_count,
  output logic [mem_port_pkg::PERF_CNT_W-1:0] o_store_count,
  output logic [mem_port_pkg::PERF_CNT_W-1:0] o_stall_count,
  // axi master
  output logic [axi_pkg::AXI_ID_W-1:0]        o_arid,
  output logic [axi_pkg::AXI_ADDR_W-1:0]      o_araddr,
  output logic                                o_arvalid,
  input  logic                                i_arready,
  input  logic [axi_pkg::AXI_ID_W-1:0]        i_rid,
  input  logic [axi_pkg::AXI_DATA_W-1:0]      i_rdata,
  input  logic                                i_rvalid,
  output logic                                o_rready,
  output logic [axi_pkg::AXI_ADDR_W-1:0]      o_awaddr,
  output logic                                o_awvalid,
  input  logic                                i_awready,
  output logic [axi_pkg::AXI_DATA_W-1:0]      o_wdata,
  output logic [axi_pkg::AXI_STRB_W-1:0]      o_wstrb,
  output logic                                o_wvalid,
  input  logic                                i_wready,
  input  logic                                i_bvalid,
  output logic                                o_bready
);
  import mem_port_pkg::*;
  import axi_pkg::*;

  logic                rd_valid;
  logic                rd_ready;
  logic [ADDR_W-1:0]   rd_addr;
  logic [AXI_ID_W-1:0] rd_id;
  logic                wb_push_valid;
  logic                wb_push_ready;
  logic                wb_empty;
  logic [ADDR_W-1:0]   wb_addr;
  logic [STRB_W-1:0]   wb_strb;
  logic [DATA_W-1:0]   wb_data;
  logic                uncached_stall;

  mem_req_arbiter u_mem_req_arbiter (
    .aclk            (aclk),
    .i_reset         (i_reset),
    .i_if_valid      (i_if_valid),
    .i_if_addr       (i_if_addr),
    .i_if_uncached   (i_if_uncached),
    .o_if_ready      (o_if_ready),
    .i_d_valid       (i_d_valid),
    .i_d_op          (i_d_op),
    .i_d_addr        (i_d_addr),
    .i_d_uncached    (i_d_uncached),
    .i_d_wstrb       (i_d_wstrb),
    .i_d_wdata       (i_d_wdata),
    .o_d_ready       (o_d_ready),
    .i_rd_ready      (rd_ready),
    .o_rd_valid      (rd_valid),
    .o_rd_addr       (rd_addr),
    .o_rd_id         (rd_id),
    .i_wb_push_ready (wb_push_ready),
    .i_wb_empty      (wb_empty),
    .o_wb_push_valid (wb_push_valid),
    .o_wb_addr       (wb_addr),
    .o_wb_strb       (wb_strb),
    .o_wb_data       (wb_data),
    .o_uncached_stall(uncached_stall)
  );

  axi_read_engine u_axi_read_engine (
    .aclk       (aclk),
    .i_reset    (i_reset),
    .i_req_valid(rd_valid),
    .i_req_addr (rd_addr),
    .i_req_id   (rd_id),
    .o_req_ready(rd_ready),
    .o_arid     (o_arid),
    .o_araddr   (o_araddr),
    .o_arvalid  (o_arvalid),
    .i_arready  (i_arready),
    .i_rid      (i_rid),
    .i_rdata    (i_rdata),
    .i_rvalid   (i_rvalid),
    .o_rready   (o_rready),
    .o_if_rvalid(o_if_rvalid),
    .o_if_rdata (o_if_rdata),
    .o_d_rvalid (o_d_rvalid),
    .o_d_rdata  (o_d_rdata)
  );

  store_write_buffer u_store_write_buffer (
    .aclk        (aclk),
    .i_reset     (i_reset),
    .i_push_valid(wb_push_valid),
    .i_push_addr (wb_addr),
    .i_push_strb (wb_strb),
    .i_push_data (wb_data),
    .o_push_ready(wb_push_ready),
    .o_empty     (wb_empty),
    .o_awaddr    (o_awaddr),
    .o_awvalid   (o_awvalid),
    .i_awready   (i_awready),
    .o_wdata     (o_wdata),
    .o_wstrb     (o_wstrb),
    .o_wvalid    (o_wvalid),
    .i_wready    (i_wready),
    .i_bvalid    (i_bvalid),
    .o_bready    (o_bready)
  );

  mem_perf_counter u_mem_perf_counter (
    .aclk            (aclk),
    .i_reset         (i_reset),
    .i_if_valid      (i_if_valid),
    .i_if_ready      (o_if_ready),
    .i_d_valid       (i_d_valid),
    .i_d_ready       (o_d_ready),
    .i_d_op          (i_d_op),
    .i_uncached_stall(uncached_stall),
    .o_fetch_count   (o_fetch_count),
    .o_load_count    (o_load_count),
    .o_store_count   (o_store_count),
    .o_stall_count   (o_stall_count)
  );

endmodule

// ==== tests/mem_port_properties.sv ====
`timescale 1ns/1ps

module mem_port_properties (
  input logic aclk,
  input logic i_reset,
  input logic i_uncached_grant,
  input logic i_wb_empty,
  input logic i_push_valid,
  input logic i_push_ready,
  input logic i_bvalid,
  input logic i_bready,
  input logic i_awvalid,
  input logic i_awready
);
  import mem_port_pkg::*;

  logic [WBUF_PTR_W:0] occupancy;
  logic                push_fire;
  logic                b_fire;

  assign push_fire = i_push_valid && i_push_ready;
  assign b_fire    = i_bvalid && i_bready;

  // occupancy tracked from push and write response handshakes
  always_ff @(posedge aclk) begin
    if (i_reset) begin
      occupancy <= '0;
    end else if (push_fire && !b_fire) begin
      occupancy <= occupancy + (WBUF_PTR_W+1)'(1);
    end else if (b_fire && !push_fire) begin
      occupancy <= occupancy - (WBUF_PTR_W+1)'(1);
    end
  end

  // uncached traffic stays behind buffered stores
  uncached_order: assert property (@(posedge aclk) disable iff (i_reset)
    i_uncached_grant |-> i_wb_empty)
    else $error("uncached request granted while the write buffer holds stores");

  full_blocks_push: assert property (@(posedge aclk) disable iff (i_reset)
    (occupancy == (WBUF_PTR_W+1)'(WBUF_DEPTH)) |-> !i_push_ready)
    else $error("push ready raised while the write buffer is full");

  // aw stays up until the slave takes it
  aw_stable: assert property (@(posedge aclk) disable iff (i_reset)
    (i_awvalid && !i_awready) |=> i_awvalid)
    else $error("awvalid dropped before awready");

endmodule

bind mem_req_arbiter mem_port_properties u_arb_props (
  .aclk            (aclk),
  .i_reset         (i_reset),
  .i_uncached_grant((o_if_ready && i_if_uncached) || (o_d_ready && i_d_uncached)),
  .i_wb_empty      (i_wb_empty),
  .i_push_valid    (1'b0),
  .i_push_ready    (1'b0),
  .i_bvalid        (1'b0),
  .i_bready        (1'b0),
  .i_awvalid       (1'b0),
  .i_awready       (1'b0)
);

bind store_write_buffer mem_port_properties u_wb_props (
  .aclk            (aclk),
  .i_reset         (i_reset),
  .i_uncached_grant(1'b0),
  .i_wb_empty      (o_empty),
  .i_push_valid    (i_push_valid),
  .i_push_ready    (o_push_ready),
  .i_bvalid        (i_bvalid),
  .i_bready        (o_bready),
  .i_awvalid       (o_awvalid),
  .i_awready       (i_awready)
);

// ==== tests/mem_port_tb.sv ====
`timescale 1ns/1ps

module mem_port_tb;
  import mem_port_pkg::*;
  import axi_pkg::*;

  localparam int NUM_ROWS = 16;
  localparam int CYCLE_LIMIT = NUM_ROWS * 64 + 16;
  localparam logic PORT_IF = 1'b0;
  localparam logic PORT_D = 1'b1;

  typedef struct packed {
    logic        port;
    mem_op_e     op;
    logic [31:0] addr;
    logic        unc;
    logic [3:0]  strb;
    logic [31:0] wdata;
    logic [31:0] rdata;
    logic        hold;
  } row_t;

  logic                  aclk = 1'b0;
  logic                  i_reset;
  logic                  i_if_valid;
  logic [ADDR_W-1:0]     i_if_addr;
  logic                  i_if_uncached;
  logic                  o_if_ready;
  logic                  o_if_rvalid;
  logic [DATA_W-1:0]     o_if_rdata;
  logic                  i_d_valid;
  mem_op_e               i_d_op;
  logic [ADDR_W-1:0]     i_d_addr;
  logic                  i_d_uncached;
  logic [STRB_W-1:0]     i_d_wstrb;
  logic [DATA_W-1:0]     i_d_wdata;
  logic                  o_d_ready;
  logic                  o_d_rvalid;
  logic [DATA_W-1:0]     o_d_rdata;
  logic [PERF_CNT_W-1:0] o_fetch_count;
  logic [PERF_CNT_W-1:0] o_load_count;
  logic [PERF_CNT_W-1:0] o_store_count;
  logic [PERF_CNT_W-1:0] o_stall_count;
  logic [AXI_ID_W-1:0]   o_arid;
  logic [AXI_ADDR_W-1:0] o_araddr;
  logic                  o_arvalid;
  logic                  i_arready = 1'b0;
  logic [AXI_ID_W-1:0]   i_rid = '0;
  logic [AXI_DATA_W-1:0] i_rdata = '0;
  logic                  i_rvalid = 1'b0;
  logic                  o_rready;
  logic [AXI_ADDR_W-1:0] o_awaddr;
  logic                  o_awvalid;
  logic                  i_awready = 1'b0;
  logic [AXI_DATA_W-1:0] o_wdata;
  logic [AXI_STRB_W-1:0] o_wstrb;
  logic                  o_wvalid;
  logic                  i_wready = 1'b0;
  logic                  i_bvalid = 1'b0;
  logic                  o_bready;

  // handshakes seen at the last rising edge
  logic        if_fire_q = 1'b0;
  logic        d_fire_q = 1'b0;
  logic        ar_fire = 1'b0;
  logic        r_fire = 1'b0;
  logic        aw_fire = 1'b0;
  logic        w_fire = 1'b0;
  logic        b_fire = 1'b0;
  logic        hold_req = 1'b0;
  logic        hold_q = 1'b0;
  logic [31:0] ar_addr_q = '0;
  logic [3:0]  ar_id_q = '0;
  logic [31:0] aw_addr_q = '0;
  logic [31:0] w_data_q = '0;
  logic [3:0]  w_strb_q = '0;

  // slave model state
  logic [31:0] axi_mem [1024];
  logic [31:0] shadow [1024];
  logic [31:0] lfsr = 32'h911e_7676;
  bit          mem_filled = 1'b0;
  logic        rd_pend = 1'b0;
  logic        aw_got = 1'b0;
  logic        w_got = 1'b0;
  logic        b_pend = 1'b0;
  int          ar_wait = 0;
  int          r_wait = 0;
  int          aw_wait = 0;
  int          w_wait = 0;
  int          b_wait = 0;
  int          aw_hold = 0;

  row_t rows [NUM_ROWS];
  int   n_checks = 0;
  int   n_errors = 0;
  int   n_fetch = 0;
  int   n_load = 0;
  int   n_store = 0;
  int   cycles = 0;

  mem_port_top u_mem_port_top (.*);

  always #4 aclk = ~aclk;

  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  task automatic draw_delay(output int d);
    logic [1:0] bits;
    for (int k = 0; k < 2; k++) begin
      lfsr = lfsr_step(lfsr);
      bits[k] = lfsr[0];
    end
    d = int'(bits);
  endtask

  function automatic logic [31:0] init_word(input logic [31:0] a);
    return a ^ 32'hdead_beef;
  endfunction

  function automatic logic [31:0] merge_word(input logic [31:0] old,
                                             input logic [31:0] data,
                                             input logic [3:0] strb);
    logic [31:0] res;
    res = old;
    for (int b = 0; b < 4; b++) begin
      if (strb[b]) res[8*b +: 8] = data[8*b +: 8];
    end
    return res;
  endfunction

  task automatic check_eq(input string name, input logic [31:0] got, input logic [31:0] exp);
    n_checks++;
    if (got !== exp) begin
      n_errors++;
      $display("Mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
    end
  endtask

  always @(posedge aclk) begin
    if_fire_q <= i_if_valid && o_if_ready;
    d_fire_q  <= i_d_valid && o_d_ready;
    ar_fire   <= o_arvalid && i_arready;
    r_fire    <= i_rvalid && o_rready;
    aw_fire   <= o_awvalid && i_awready;
    w_fire    <= o_wvalid && i_wready;
    b_fire    <= i_bvalid && o_bready;
    hold_q    <= hold_req;
    if (o_arvalid && i_arready) begin
      ar_addr_q <= o_araddr;
      ar_id_q   <= o_arid;
    end
    if (o_awvalid && i_awready) begin
      aw_addr_q <= o_awaddr;
    end
    if (o_wvalid && i_wready) begin
      w_data_q <= o_wdata;
      w_strb_q <= o_wstrb;
    end
  end

  // axi slave, all responses change on the falling edge
  always @(negedge aclk) begin
    if (!mem_filled) begin
      for (int i = 0; i < 1024; i++) axi_mem[i] = init_word(32'(i) << 2);
      mem_filled = 1'b1;
    end
    if (r_fire) i_rvalid = 1'b0;
    if (ar_fire) begin
      i_arready = 1'b0;
      rd_pend = 1'b1;
      draw_delay(ar_wait);
      draw_delay(r_wait);
    end else if (o_arvalid && !i_arready) begin
      if (ar_wait == 0) i_arready = 1'b1;
      else ar_wait--;
    end
    if (rd_pend) begin
      if (r_wait == 0) begin
        i_rvalid = 1'b1;
        i_rid = ar_id_q;
        i_rdata = axi_mem[ar_addr_q[11:2]];
        rd_pend = 1'b0;
      end else begin
        r_wait--;
      end
    end
    if (b_fire) i_bvalid = 1'b0;
    if (hold_q) aw_hold = 8;
    if (aw_fire) begin
      i_awready = 1'b0;
      aw_got = 1'b1;
      draw_delay(aw_wait);
    end else if (aw_hold > 0) begin
      i_awready = 1'b0;
      aw_hold--;
    end else if (o_awvalid && !i_awready) begin
      if (aw_wait == 0) i_awready = 1'b1;
      else aw_wait--;
    end
    if (w_fire) begin
      i_wready = 1'b0;
      w_got = 1'b1;
      draw_delay(w_wait);
    end else if (o_wvalid && !i_wready) begin
      if (w_wait == 0) i_wready = 1'b1;
      else w_wait--;
    end
    if (aw_got && w_got) begin
      axi_mem[aw_addr_q[11:2]] = merge_word(axi_mem[aw_addr_q[11:2]], w_data_q, w_strb_q);
      aw_got = 1'b0;
      w_got = 1'b0;
      b_pend = 1'b1;
      draw_delay(b_wait);
    end
    if (b_pend) begin
      if (b_wait == 0) begin
        i_bvalid = 1'b1;
        b_pend = 1'b0;
      end else begin
        b_wait--;
      end
    end
  end

  always @(posedge aclk) begin
    cycles <= cycles + 1;
    if (cycles == CYCLE_LIMIT) begin
      $display("Timeout: the test table did not finish within %0d cycles", CYCLE_LIMIT);
      $display("Simulation failed");
      $finish;
    end
  end

  // port, op, addr, uncached, strobe, write data, read data, awready hold
  task automatic load_table();
    rows[0]  = '{PORT_D,  MEM_LOAD,  32'h100, 1'b0, 4'h0, 32'h0, 32'hdead_bfef, 1'b0};
    rows[1]  = '{PORT_IF, MEM_LOAD,  32'h104, 1'b0, 4'h0, 32'h0, 32'hdead_bfeb, 1'b0};
    rows[2]  = '{PORT_D,  MEM_LOAD,  32'h108, 1'b0, 4'h0, 32'h0, 32'hdead_bfe7, 1'b0};
    rows[3]  = '{PORT_IF, MEM_LOAD,  32'h10c, 1'b0, 4'h0, 32'h0, 32'hdead_bfe3, 1'b0};
    rows[4]  = '{PORT_D,  MEM_STORE, 32'h200, 1'b0, 4'hf, 32'h1111_2222, 32'h0, 1'b0};
    rows[5]  = '{PORT_D,  MEM_STORE, 32'h204, 1'b0, 4'h3, 32'haaaa_bbbb, 32'h0, 1'b0};
    rows[6]  = '{PORT_D,  MEM_STORE, 32'h208, 1'b0, 4'hc, 32'hcccc_dddd, 32'h0, 1'b0};
    rows[7]  = '{PORT_D,  MEM_LOAD,  32'h200, 1'b1, 4'h0, 32'h0, 32'h1111_2222, 1'b0};
    rows[8]  = '{PORT_IF, MEM_LOAD,  32'h204, 1'b1, 4'h0, 32'h0, 32'hdead_bbbb, 1'b0};
    rows[9]  = '{PORT_D,  MEM_LOAD,  32'h208, 1'b1, 4'h0, 32'h0, 32'hcccc_bce7, 1'b0};
    rows[10] = '{PORT_D,  MEM_STORE, 32'h20c, 1'b0, 4'h5, 32'h1234_5678, 32'h0, 1'b0};
    rows[11] = '{PORT_D,  MEM_LOAD,  32'h20c, 1'b1, 4'h0, 32'h0, 32'hde34_bc78, 1'b1};
    rows[12] = '{PORT_IF, MEM_LOAD,  32'h110, 1'b0, 4'h0, 32'h0, 32'hdead_bfff, 1'b0};
    rows[13] = '{PORT_D,  MEM_LOAD,  32'h114, 1'b0, 4'h0, 32'h0, 32'hdead_bffb, 1'b0};
    rows[14] = '{PORT_D,  MEM_STORE, 32'h104, 1'b0, 4'h8, 32'h7700_0000, 32'h0, 1'b0};
    rows[15] = '{PORT_IF, MEM_LOAD,  32'h104, 1'b1, 4'h0, 32'h0, 32'h77ad_bfeb, 1'b0};
  endtask

  task automatic apply_row(input row_t r);
    logic        fired;
    logic [31:0] got;
    logic [31:0] stall_before;
    stall_before = o_stall_count;
    if (r.port == PORT_IF) begin
      i_if_valid = 1'b1;
      i_if_addr = r.addr;
      i_if_uncached = r.unc;
    end else begin
      i_d_valid = 1'b1;
      i_d_op = r.op;
      i_d_addr = r.addr;
      i_d_uncached = r.unc;
      i_d_wstrb = r.strb;
      i_d_wdata = r.wdata;
    end
    hold_req = r.hold;
    fired = 1'b0;
    while (!fired) begin
      @(negedge aclk);
      hold_req = 1'b0;
      fired = (r.port == PORT_IF) ? if_fire_q : d_fire_q;
    end
    i_if_valid = 1'b0;
    i_d_valid = 1'b0;
    if (r.port == PORT_D && r.op == MEM_STORE) begin
      shadow[r.addr[11:2]] = merge_word(shadow[r.addr[11:2]], r.wdata, r.strb);
    end else begin
      while (!o_if_rvalid && !o_d_rvalid) @(negedge aclk);
      got = (r.port == PORT_IF) ? o_if_rdata : o_d_rdata;
      check_eq("o_if_rvalid", 32'(o_if_rvalid), 32'(r.port == PORT_IF));
      check_eq("o_d_rvalid", 32'(o_d_rvalid), 32'(r.port == PORT_D));
      check_eq("shadow word", shadow[r.addr[11:2]], r.rdata);
      check_eq((r.port == PORT_IF) ? "o_if_rdata" : "o_d_rdata", got, r.rdata);
    end
    if (r.hold) begin
      check_eq("o_stall_count increase", 32'(o_stall_count > stall_before), 32'd1);
    end
  endtask

  initial begin
    i_reset = 1'b1;
    i_if_valid = 1'b0;
    i_if_addr = '0;
    i_if_uncached = 1'b0;
    i_d_valid = 1'b0;
    i_d_op = MEM_LOAD;
    i_d_addr = '0;
    i_d_uncached = 1'b0;
    i_d_wstrb = '0;
    i_d_wdata = '0;
    for (int i = 0; i < 1024; i++) shadow[i] = init_word(32'(i) << 2);
    load_table();
    repeat (4) @(negedge aclk);
    i_reset = 1'b0;
    foreach (rows[i]) begin
      if (rows[i].port == PORT_IF) n_fetch++;
      else if (rows[i].op == MEM_STORE) n_store++;
      else n_load++;
      apply_row(rows[i]);
    end
    repeat (2) @(negedge aclk);
    check_eq("o_fetch_count", o_fetch_count, 32'(n_fetch));
    check_eq("o_load_count", o_load_count, 32'(n_load));
    check_eq("o_store_count", o_store_count, 32'(n_store));
    $display("checks: %0d, errors: %0d", n_checks, n_errors);
    if (n_errors == 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

// ==== list.f ====
hw/axi_pkg.sv
hw/mem_port_pkg.sv
hw/mem_req_arbiter.sv
hw/axi_read_engine.sv
hw/store_write_buffer.sv
hw/mem_perf_counter.sv
hw/mem_port_top.sv
tests/mem_port_properties.sv
tests/mem_port_tb.sv

// ==== run.sh ====
#!/bin/sh
# build and run the memory port testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f list.f --top-module mem_port_tb -Mdir obj_dir

./obj_dir/Vmem_port_tb | tee sim.log

if grep -q "^Simulation passed$" sim.log; then
  exit 0
else
  exit 1
fi
